/* hdl/mem_req_pkg.sv */
//////////////////////////////////////////////////
// Cache-side request and response widths, port
// ids and thread-id pool sizing
//////////////////////////////////////////////////
package mem_req_pkg;

    localparam int PA_WIDTH       = 40;
    localparam int MEM_ID_WIDTH   = 4;
    localparam int MEM_DATA_WIDTH = 128;

    typedef logic [PA_WIDTH-1:0]         paddr_t;
    typedef logic [MEM_ID_WIDTH-1:0]     mem_id_t;
    typedef logic [2:0]                  pid_t;
    typedef logic [MEM_DATA_WIDTH-1:0]   mem_data_t;
    typedef logic [MEM_DATA_WIDTH/8-1:0] mem_be_t;
    typedef logic [2:0]                  mem_size_t;   // log2 of byte count

    typedef enum logic [1:0] {
        READ  = 2'b00,
        WRITE = 2'b01
    } mem_cmd_e;

    // Source ports of the cache request mux
    localparam pid_t PID_DCACHE    = 3'd1;
    localparam pid_t PID_WBUF      = 3'd2;
    localparam pid_t PID_UNC_READ  = 3'd3;
    localparam pid_t PID_UNC_WRITE = 3'd4;

    // Thread ids bound the outstanding requests
    localparam int TID_WIDTH = 2;
    localparam int NUM_TIDS  = 4;

    typedef logic [TID_WIDTH-1:0] tid_t;

endpackage

/* hdl/l15_msg_pkg.sv */
//////////////////////////////////////////////////
// L1.5 message types: request and return type
// enums, size codes, data and byte-enable widths
//////////////////////////////////////////////////
package l15_msg_pkg;

    // Request data lane seen by the L1.5
    localparam int L15_DATA_WIDTH = 64;
    localparam int OFFSET_WIDTH   = 3;  // Byte offset inside one lane

    typedef logic [L15_DATA_WIDTH-1:0]   l15_data_t;
    typedef logic [L15_DATA_WIDTH/8-1:0] l15_be_t;
    typedef logic [2:0]                  l15_size_t;

    typedef enum logic [4:0] {
        LOAD  = 5'b00000,
        STORE = 5'b00001
    } l15_rqtype_e;

    // Return types, encodings follow the CPX message format
    typedef enum logic [3:0] {
        LOAD_RET = 4'b0000,
        ST_ACK   = 4'b0100,
        ERR_RET  = 4'b1100
    } l15_rtype_e;

    // Size codes, log2 of the byte count plus one
    localparam l15_size_t SIZE_0B  = 3'd0;
    localparam l15_size_t SIZE_1B  = 3'd1;
    localparam l15_size_t SIZE_2B  = 3'd2;
    localparam l15_size_t SIZE_4B  = 3'd3;
    localparam l15_size_t SIZE_8B  = 3'd4;
    localparam l15_size_t SIZE_16B = 3'd5;
    localparam l15_size_t SIZE_32B = 3'd6;
    localparam l15_size_t SIZE_64B = 3'd7;   // Also used for odd byte counts

endpackage

/* hdl/store_shaper.sv */
//////////////////////////////////////////////////
// Cached-store shaping: mask reduction, size code,
// aligned address and big-endian store lane
//////////////////////////////////////////////////
`timescale 1ns/1ps

module store_shaper
    import mem_req_pkg::*;
    import l15_msg_pkg::*;
(
    input  paddr_t    req_addr_i,
    input  mem_data_t req_wdata_i,
    input  mem_be_t   req_wbe_i,
    output l15_size_t st_size_o,
    output paddr_t    st_addr_o,
    output l15_data_t st_data_o,
    output l15_be_t   st_be_o
);

    l15_be_t                 be_or;      // Both mask halves folded on one lane
    logic [OFFSET_WIDTH-1:0] first_one;
    logic [4:0]              num_ones;   // 0 to 16 set bits

    assign be_or    = req_wbe_i[7:0] | req_wbe_i[15:8];
    assign num_ones = 5'($countones(req_wbe_i));

    // Lowest set bit, scanned from the top so the last hit wins
    always_comb begin
        first_one = '0;
        for (int i = L15_DATA_WIDTH/8 - 1; i >= 0; i--) begin
            if (be_or[i]) begin
                first_one = OFFSET_WIDTH'(i);
            end
        end
    end

    // Store start aligned inside the 8-byte lane
    assign st_addr_o = {req_addr_i[PA_WIDTH-1:OFFSET_WIDTH], first_one};

    always_comb begin
        case (num_ones)
            5'd0:    st_size_o = SIZE_0B;
            5'd1:    st_size_o = SIZE_1B;
            5'd2:    st_size_o = SIZE_2B;
            5'd4:    st_size_o = SIZE_4B;
            5'd8:    st_size_o = SIZE_8B;
            5'd16:   st_size_o = SIZE_16B;
            default: st_size_o = SIZE_64B;  // Irregular masks
        endcase
    end

    // L1.5 side is big endian
    always_comb begin
        for (int i = 0; i < L15_DATA_WIDTH/8; i++) begin
            st_data_o[i*8 +: 8]                = req_wdata_i[L15_DATA_WIDTH-1-i*8 -: 8];
            st_be_o[L15_DATA_WIDTH/8 - 1 - i] = be_or[i];
        end
    end

endmodule

/* hdl/req_decoder.sv */
//////////////////////////////////////////////////
// Decode stage: request class and L1.5 fields
//////////////////////////////////////////////////
`timescale 1ns/1ps

module req_decoder
    import mem_req_pkg::*;
    import l15_msg_pkg::*;
(
    input  pid_t        req_pid_i,
    input  mem_cmd_e    req_cmd_i,
    input  logic        req_cacheable_i,
    input  paddr_t      req_addr_i,
    input  mem_size_t   req_size_i,
    input  mem_data_t   req_wdata_i,
    input  mem_be_t     req_wbe_i,
    output l15_rqtype_e rqtype_o,
    output logic        nc_o,
    output l15_size_t   size_o,
    output paddr_t      addr_o,
    output l15_data_t   data_o,
    output l15_be_t     be_o
);

    logic      is_store;
    logic      is_cached_store;
    l15_size_t st_size;
    paddr_t    st_addr;

    // Write buffer and uncached write port carry the stores
    assign is_store        = ((req_pid_i == PID_WBUF) || (req_pid_i == PID_UNC_WRITE))
                             && (req_cmd_i == WRITE);
    assign is_cached_store = (req_pid_i == PID_WBUF) && (req_cmd_i == WRITE);

    store_shaper store_shaper_i (
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_wbe_i   (req_wbe_i),
        .st_size_o   (st_size),
        .st_addr_o   (st_addr),
        .st_data_o   (data_o),
        .st_be_o     (be_o)
    );

    assign rqtype_o = is_store ? STORE : LOAD;
    assign nc_o     = ~req_cacheable_i;
    assign size_o   = is_cached_store ? st_size : l15_size_t'(req_size_i + mem_size_t'(1));
    assign addr_o   = is_cached_store ? st_addr : req_addr_i;

    // Port id zero is the idle value of the request mux
    always_comb begin
        if (req_pid_i != '0) begin
            assert (req_pid_i inside {PID_DCACHE, PID_WBUF, PID_UNC_READ, PID_UNC_WRITE})
                else $error("unsupported request port id %0d", req_pid_i);
        end
    end

endmodule

/* hdl/thread_id_pool.sv */
//////////////////////////////////////////////////
// Free list of L1.5 thread ids
//////////////////////////////////////////////////
`timescale 1ns/1ps

module thread_id_pool
    import mem_req_pkg::*;
(
    input  logic clk_i,
    input  logic rst_ni,
    input  logic take_i,
    input  logic release_i,
    input  tid_t release_tid_i,
    output logic avail_o,
    output tid_t head_tid_o
);

    tid_t               fifo_q [NUM_TIDS];
    tid_t               rd_ptr_q;
    tid_t               wr_ptr_q;   // Wraps onto rd_ptr_q when full
    logic [TID_WIDTH:0] count_q;
    logic               full;

    assign avail_o    = (count_q != '0);
    assign head_tid_o = fifo_q[rd_ptr_q];
    assign full       = (count_q == (TID_WIDTH+1)'(NUM_TIDS));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NUM_TIDS; i++) begin
                fifo_q[i] <= tid_t'(i);     // All ids free, handed out in order
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= (TID_WIDTH+1)'(NUM_TIDS);
        end else begin
            if (take_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (release_i) begin
                fifo_q[wr_ptr_q] <= release_tid_i;
                wr_ptr_q         <= wr_ptr_q + 1'b1;
            end
            case ({take_i, release_i})
                2'b10:   count_q <= count_q - 1'b1;
                2'b01:   count_q <= count_q + 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    take_when_empty_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        take_i |-> avail_o)
        else $error("thread id taken from an empty pool");

    release_when_full_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        release_i |-> !full)
        else $error("thread id released into a full pool");

endmodule

/* hdl/issue_ctrl.sv */
//////////////////////////////////////////////////
// Issue stage: L1.5 header-ack/ack handshake FSM
// and the thread id to requester table
//////////////////////////////////////////////////
`timescale 1ns/1ps

module issue_ctrl
    import mem_req_pkg::*;
(
    input  logic    clk_i,
    input  logic    rst_ni,
    input  logic    req_valid_i,
    input  mem_id_t req_id_i,
    input  pid_t    req_pid_i,
    input  logic    tid_avail_i,
    input  tid_t    tid_head_i,
    input  logic    l15_header_ack_i,
    input  logic    l15_ack_i,
    input  tid_t    lookup_tid_i,
    output logic    req_ready_o,
    output logic    l15_val_o,
    output tid_t    l15_threadid_o,
    output logic    tid_take_o,
    output mem_id_t lookup_id_o,
    output pid_t    lookup_pid_o
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT_HDR,
        WAIT_ACK
    } issue_state_e;

    issue_state_e state_q, state_d;
    logic         accept;

    mem_id_t id_tab [NUM_TIDS];     // Requester id per thread id
    pid_t    pid_tab [NUM_TIDS];

    always_comb begin
        state_d   = state_q;
        l15_val_o = 1'b0;
        accept    = 1'b0;
        case (state_q)
            IDLE: begin
                if (req_valid_i && tid_avail_i) begin
                    l15_val_o = 1'b1;
                    if (l15_header_ack_i && l15_ack_i) begin
                        accept = 1'b1;          // Both acks at once
                    end else if (l15_header_ack_i) begin
                        state_d = WAIT_ACK;
                    end else begin
                        state_d = WAIT_HDR;
                    end
                end
            end
            WAIT_HDR: begin
                l15_val_o = 1'b1;   // Keep offering until the header is taken
                if (l15_header_ack_i) begin
                    if (l15_ack_i) begin
                        accept  = 1'b1;
                        state_d = IDLE;
                    end else begin
                        state_d = WAIT_ACK;
                    end
                end
            end
            WAIT_ACK: begin
                // Valid drops here but the fields stay put
                if (l15_ack_i) begin
                    accept  = 1'b1;
                    state_d = IDLE;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    assign req_ready_o    = accept;
    assign tid_take_o     = accept;
    assign l15_threadid_o = tid_head_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            id_tab[tid_head_i]  <= req_id_i;
            pid_tab[tid_head_i] <= req_pid_i;
        end
    end

    assign lookup_id_o  = id_tab[lookup_tid_i];
    assign lookup_pid_o = pid_tab[lookup_tid_i];

    // Cache keeps its request up until the handshake completes
    ready_needs_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
        req_ready_o |-> req_valid_i)
        else $error("request accepted without a valid request");

endmodule

/* hdl/return_router.sv */
//////////////////////////////////////////////////
// Return stage: response routing, data swap and
// thread id release
//////////////////////////////////////////////////
`timescale 1ns/1ps

module return_router
    import mem_req_pkg::*;
    import l15_msg_pkg::*;
(
    input  logic       l15_rtrn_val_i,
    input  l15_rtype_e l15_rtrn_type_i,
    input  tid_t       l15_rtrn_threadid_i,
    input  mem_data_t  l15_rtrn_data_i,
    input  logic       resp_ready_i,
    input  mem_id_t    lookup_id_i,
    input  pid_t       lookup_pid_i,
    output logic       l15_req_ack_o,
    output logic       resp_valid_o,
    output pid_t       resp_pid_o,
    output mem_id_t    resp_id_o,
    output logic       resp_error_o,
    output mem_data_t  resp_data_o,
    output logic       tid_release_o,
    output tid_t       release_tid_o
);

    logic consumed;

    assign consumed      = l15_rtrn_val_i & resp_ready_i;
    assign l15_req_ack_o = consumed;    // L1.5 holds the return until then
    assign tid_release_o = consumed;
    assign release_tid_o = l15_rtrn_threadid_i;

    assign resp_valid_o = l15_rtrn_val_i;
    assign resp_id_o    = lookup_id_i;
    assign resp_pid_o   = lookup_pid_i;
    assign resp_error_o = (l15_rtrn_type_i == ERR_RET);

    // Big endian to little endian, one 64-bit word at a time
    always_comb begin
        for (int w = 0; w < MEM_DATA_WIDTH/L15_DATA_WIDTH; w++) begin
            for (int b = 0; b < L15_DATA_WIDTH/8; b++) begin
                resp_data_o[w*L15_DATA_WIDTH + b*8 +: 8] =
                    l15_rtrn_data_i[w*L15_DATA_WIDTH + (L15_DATA_WIDTH/8 - 1 - b)*8 +: 8];
            end
        end
    end

endmodule

/* hdl/l15_adapter.sv */
//////////////////////////////////////////////////
// Cache memory port to L1.5 adapter, top level
//////////////////////////////////////////////////
`timescale 1ns/1ps

module l15_adapter
    import mem_req_pkg::*;
    import l15_msg_pkg::*;
(
    input  logic        clk_i,
    input  logic        rst_ni,
    // Cache request
    input  logic        req_valid_i,
    input  pid_t        req_pid_i,
    input  mem_id_t     req_id_i,
    input  mem_cmd_e    req_cmd_i,
    input  logic        req_cacheable_i,
    input  paddr_t      req_addr_i,
    input  mem_size_t   req_size_i,
    input  mem_data_t   req_wdata_i,
    input  mem_be_t     req_wbe_i,
    output logic        req_ready_o,
    // L1.5 request
    output logic        l15_val_o,
    output l15_rqtype_e l15_rqtype_o,
    output logic        l15_nc_o,
    output l15_size_t   l15_size_o,
    output tid_t        l15_threadid_o,
    output paddr_t      l15_address_o,
    output l15_data_t   l15_data_o,
    output l15_be_t     l15_be_o,
    input  logic        l15_header_ack_i,
    input  logic        l15_ack_i,
    // L1.5 return
    input  logic        l15_rtrn_val_i,
    input  l15_rtype_e  l15_rtrn_type_i,
    input  tid_t        l15_rtrn_threadid_i,
    input  mem_data_t   l15_rtrn_data_i,
    output logic        l15_req_ack_o,
    // Cache response
    output logic        resp_valid_o,
    output pid_t        resp_pid_o,
    output mem_id_t     resp_id_o,
    output logic        resp_error_o,
    output mem_data_t   resp_data_o,
    input  logic        resp_ready_i
);

    logic    tid_avail;
    tid_t    tid_head;
    logic    tid_take;
    logic    tid_release;
    tid_t    release_tid;   // Also the table lookup index
    mem_id_t lookup_id;
    pid_t    lookup_pid;

    req_decoder req_decoder_i (
        .req_pid_i       (req_pid_i),
        .req_cmd_i       (req_cmd_i),
        .req_cacheable_i (req_cacheable_i),
        .req_addr_i      (req_addr_i),
        .req_size_i      (req_size_i),
        .req_wdata_i     (req_wdata_i),
        .req_wbe_i       (req_wbe_i),
        .rqtype_o        (l15_rqtype_o),
        .nc_o            (l15_nc_o),
        .size_o          (l15_size_o),
        .addr_o          (l15_address_o),
        .data_o          (l15_data_o),
        .be_o            (l15_be_o)
    );

    thread_id_pool thread_id_pool_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .take_i        (tid_take),
        .release_i     (tid_release),
        .release_tid_i (release_tid),
        .avail_o       (tid_avail),
        .head_tid_o    (tid_head)
    );

    issue_ctrl issue_ctrl_i (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .req_valid_i      (req_valid_i),
        .req_id_i         (req_id_i),
        .req_pid_i        (req_pid_i),
        .tid_avail_i      (tid_avail),
        .tid_head_i       (tid_head),
        .l15_header_ack_i (l15_header_ack_i),
        .l15_ack_i        (l15_ack_i),
        .lookup_tid_i     (release_tid),
        .req_ready_o      (req_ready_o),
        .l15_val_o        (l15_val_o),
        .l15_threadid_o   (l15_threadid_o),
        .tid_take_o       (tid_take),
        .lookup_id_o      (lookup_id),
        .lookup_pid_o     (lookup_pid)
    );

    return_router return_router_i (
        .l15_rtrn_val_i      (l15_rtrn_val_i),
        .l15_rtrn_type_i     (l15_rtrn_type_i),
        .l15_rtrn_threadid_i (l15_rtrn_threadid_i),
        .l15_rtrn_data_i     (l15_rtrn_data_i),
        .resp_ready_i        (resp_ready_i),
        .lookup_id_i         (lookup_id),
        .lookup_pid_i        (lookup_pid),
        .l15_req_ack_o       (l15_req_ack_o),
        .resp_valid_o        (resp_valid_o),
        .resp_pid_o          (resp_pid_o),
        .resp_id_o           (resp_id_o),
        .resp_error_o        (resp_error_o),
        .resp_data_o         (resp_data_o),
        .tid_release_o       (tid_release),
        .release_tid_o       (release_tid)
    );

endmodule

/* dv/tb_l15_adapter.sv */
//////////////////////////////////////////////////
// Testbench for l15_adapter: L1.5 responder model,
// reference function, checker and watchdog
//////////////////////////////////////////////////
`timescale 1ns/1ps

module tb_l15_adapter
    import mem_req_pkg::*;
    import l15_msg_pkg::*;
();

    localparam int WATCHDOG_NS = 200 * 40 * 20;  // Transactions x cycles x period
    localparam int K_LOAD = 0;
    localparam int K_CST  = 1;   // Cached store
    localparam int K_UST  = 2;
    localparam int K_MIX  = 3;

    typedef struct packed {
        pid_t      pid;
        mem_id_t   id;
        mem_cmd_e  cmd;
        logic      cacheable;
        paddr_t    addr;
        mem_size_t size;
        mem_data_t wdata;
        mem_be_t   wbe;
    } req_t;

    logic        clk_i = 1'b0;
    logic        rst_ni;
    logic        req_valid_i;
    pid_t        req_pid_i;
    mem_id_t     req_id_i;
    mem_cmd_e    req_cmd_i;
    logic        req_cacheable_i;
    paddr_t      req_addr_i;
    mem_size_t   req_size_i;
    mem_data_t   req_wdata_i;
    mem_be_t     req_wbe_i;
    logic        req_ready_o;
    logic        l15_val_o;
    l15_rqtype_e l15_rqtype_o;
    logic        l15_nc_o;
    l15_size_t   l15_size_o;
    tid_t        l15_threadid_o;
    paddr_t      l15_address_o;
    l15_data_t   l15_data_o;
    l15_be_t     l15_be_o;
    logic        l15_header_ack_i;
    logic        l15_ack_i;
    logic        l15_rtrn_val_i;
    l15_rtype_e  l15_rtrn_type_i;
    tid_t        l15_rtrn_threadid_i;
    mem_data_t   l15_rtrn_data_i;
    logic        l15_req_ack_o;
    logic        resp_valid_o;
    pid_t        resp_pid_o;
    mem_id_t     resp_id_o;
    logic        resp_error_o;
    mem_data_t   resp_data_o;
    logic        resp_ready_i;

    // Driver and responder state
    int   seed = 62264;
    req_t pending[$];
    req_t cur_req;
    logic req_active;      // Driven, not yet accepted
    logic hdr_taken;       // Header acked, ack still owed
    logic rtrn_active;
    logic allow_ret;
    tid_t issued_tids[$];  // Accepted ids with no return yet
    int   seq_errors = 0;

    // Checker state
    tid_t    free_tids[$] = '{2'd0, 2'd1, 2'd2, 2'd3};
    mem_id_t exp_id [NUM_TIDS];
    pid_t    exp_pid [NUM_TIDS];
    logic    hdr_seen = 1'b0;   // Header acked, ack outstanding
    int      accepted = 0;
    int      checks = 0;
    int      errors = 0;

    l15_adapter l15_adapter_i (.*);

    always #10 clk_i = ~clk_i;

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Masks with 0, 1, 2, 4, 8 or 16 bytes, or irregular
    function automatic mem_be_t make_mask();
        int pick;
        int ones;
        pick = rnd(7);
        if (pick == 0) return '0;
        if (pick == 5) return '1;
        if (pick == 6) return mem_be_t'($random(seed));
        ones = 1 << (pick - 1);
        return mem_be_t'(((1 << ones) - 1) << (rnd(16 / ones) * ones));
    endfunction

    function automatic req_t make_req(input int kind);
        req_t r;
        int   k;
        k = (kind == K_MIX) ? rnd(3) : kind;
        r.id    = mem_id_t'(rnd(16));
        r.addr  = paddr_t'({$random(seed), $random(seed)});
        r.wdata = {$random(seed), $random(seed), $random(seed), $random(seed)};
        r.wbe   = '0;
        case (k)
            K_LOAD: begin
                r.pid       = (rnd(2) == 0) ? PID_DCACHE : PID_UNC_READ;
                r.cacheable = (r.pid == PID_DCACHE);
                r.cmd       = READ;
                r.size      = mem_size_t'(rnd(5));
            end
            K_CST: begin
                r.pid       = PID_WBUF;
                r.cacheable = 1'b1;
                r.cmd       = WRITE;
                r.size      = 3'd3;
                r.wbe       = make_mask();
            end
            default: begin
                r.pid       = PID_UNC_WRITE;
                r.cacheable = 1'b0;
                r.cmd       = WRITE;
                r.size      = mem_size_t'(rnd(4));
                r.wbe       = mem_be_t'($random(seed));
            end
        endcase
        return r;
    endfunction

    // Expected L1.5 request fields
    function automatic void ref_request(input req_t r, output l15_rqtype_e typ,
                                        output logic nc, output l15_size_t size,
                                        output paddr_t addr, output l15_data_t data,
                                        output l15_be_t be);
        logic [7:0] lane;
        int         ones;
        int         low;
        logic       store;
        lane = r.wbe[7:0] | r.wbe[15:8];
        ones = 0;
        low  = -1;
        for (int b = 0; b < 16; b++) begin
            if (r.wbe[b]) ones++;
        end
        for (int b = 0; b < 8; b++) begin
            if (lane[b] && low < 0) low = b;
        end
        if (low < 0) low = 0;   // Empty mask
        store = (r.pid == PID_WBUF || r.pid == PID_UNC_WRITE) && r.cmd == WRITE;
        typ   = store ? STORE : LOAD;
        nc    = !r.cacheable;
        size  = l15_size_t'(r.size + 3'd1);
        addr  = r.addr;
        if (store && r.pid == PID_WBUF) begin
            addr = {r.addr[PA_WIDTH-1:3], 3'(low)};
            case (ones)
                0:       size = SIZE_0B;
                1:       size = SIZE_1B;
                2:       size = SIZE_2B;
                4:       size = SIZE_4B;
                8:       size = SIZE_8B;
                16:      size = SIZE_16B;
                default: size = SIZE_64B;
            endcase
        end
        for (int b = 0; b < 8; b++) begin
            data[8*b +: 8] = r.wdata[8*(7-b) +: 8];
            be[7-b]        = lane[b];
        end
    endfunction

    function automatic mem_data_t swap_words(input mem_data_t x);
        mem_data_t y;
        for (int w = 0; w < 2; w++) begin
            for (int b = 0; b < 8; b++) begin
                y[64*w + 8*b +: 8] = x[64*w + 8*(7-b) +: 8];
            end
        end
        return y;
    endfunction

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] exp);
        errors++;
        $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic check_issue();
        l15_rqtype_e e_type;
        logic        e_nc;
        l15_size_t   e_size;
        paddr_t      e_addr;
        l15_data_t   e_data;
        l15_be_t     e_be;
        tid_t        e_tid;
        ref_request(cur_req, e_type, e_nc, e_size, e_addr, e_data, e_be);
        e_tid = free_tids.pop_front();   // Pool hands ids out in FIFO order
        checks++;
        if (l15_threadid_o !== e_tid)
            report_mismatch("l15_threadid_o", 128'(l15_threadid_o), 128'(e_tid));
        if (l15_rqtype_o !== e_type)
            report_mismatch("l15_rqtype_o", 128'(l15_rqtype_o), 128'(e_type));
        if (l15_nc_o !== e_nc)
            report_mismatch("l15_nc_o", 128'(l15_nc_o), 128'(e_nc));
        if (l15_size_o !== e_size)
            report_mismatch("l15_size_o", 128'(l15_size_o), 128'(e_size));
        if (l15_address_o !== e_addr)
            report_mismatch("l15_address_o", 128'(l15_address_o), 128'(e_addr));
        if (e_type == STORE) begin
            if (l15_data_o !== e_data)
                report_mismatch("l15_data_o", 128'(l15_data_o), 128'(e_data));
            if (l15_be_o !== e_be)
                report_mismatch("l15_be_o", 128'(l15_be_o), 128'(e_be));
        end
        exp_id[e_tid]  = cur_req.id;
        exp_pid[e_tid] = cur_req.pid;
        accepted++;
    endtask

    task automatic check_response();
        tid_t t;
        t = l15_rtrn_threadid_i;
        checks++;
        if (resp_id_o !== exp_id[t])
            report_mismatch("resp_id_o", 128'(resp_id_o), 128'(exp_id[t]));
        if (resp_pid_o !== exp_pid[t])
            report_mismatch("resp_pid_o", 128'(resp_pid_o), 128'(exp_pid[t]));
        if (resp_error_o !== (l15_rtrn_type_i == ERR_RET))
            report_mismatch("resp_error_o", 128'(resp_error_o),
                            128'(l15_rtrn_type_i == ERR_RET));
        if (resp_data_o !== swap_words(l15_rtrn_data_i))
            report_mismatch("resp_data_o", resp_data_o, swap_words(l15_rtrn_data_i));
        free_tids.push_back(t);   // Usable from the next cycle
    endtask

    // Compares at every acceptance and every consumed response
    always @(posedge clk_i) begin
        logic exp_val;
        logic exp_ready;
        if (rst_ni) begin
            // Offer needs a request and a free id, none while the ack is owed
            exp_val   = req_valid_i && !hdr_seen && (free_tids.size() > 0);
            exp_ready = hdr_seen ? (req_valid_i && l15_ack_i)
                                 : (exp_val && l15_header_ack_i && l15_ack_i);
            if (l15_val_o !== exp_val)
                report_mismatch("l15_val_o", 128'(l15_val_o), 128'(exp_val));
            if (req_ready_o !== exp_ready)
                report_mismatch("req_ready_o", 128'(req_ready_o), 128'(exp_ready));
            if (l15_req_ack_o !== (l15_rtrn_val_i && resp_ready_i))
                report_mismatch("l15_req_ack_o", 128'(l15_req_ack_o),
                                128'(l15_rtrn_val_i && resp_ready_i));
            if (resp_valid_o !== l15_rtrn_val_i)
                report_mismatch("resp_valid_o", 128'(resp_valid_o), 128'(l15_rtrn_val_i));
            if (req_ready_o) check_issue();
            if (l15_rtrn_val_i && resp_ready_i) check_response();
            if (exp_ready) begin
                hdr_seen = 1'b0;
            end else if (exp_val && l15_header_ack_i) begin
                hdr_seen = 1'b1;   // Header taken, ack comes later
            end
        end
    end

    // One cycle: observe handshakes at the rising edge, drive at the falling edge
    task automatic run_cycle();
        int idx;
        @(posedge clk_i);
        if (req_ready_o) begin
            req_active = 1'b0;
            hdr_taken  = 1'b0;
            issued_tids.push_back(l15_threadid_o);
        end else if (l15_val_o && l15_header_ack_i && !l15_ack_i) begin
            hdr_taken = 1'b1;
        end
        if (l15_req_ack_o) rtrn_active = 1'b0;
        @(negedge clk_i);
        if (!req_active && pending.size() > 0 && rnd(4) != 0) begin
            cur_req    = pending.pop_front();
            req_active = 1'b1;
        end
        req_valid_i     = req_active;
        req_pid_i       = cur_req.pid;
        req_id_i        = cur_req.id;
        req_cmd_i       = cur_req.cmd;
        req_cacheable_i = cur_req.cacheable;
        req_addr_i      = cur_req.addr;
        req_size_i      = cur_req.size;
        req_wdata_i     = cur_req.wdata;
        req_wbe_i       = cur_req.wbe;
        // Header ack first, ack in the same cycle or later
        l15_header_ack_i = !hdr_taken && (rnd(2) == 1);
        l15_ack_i        = hdr_taken ? (rnd(3) == 0) : (l15_header_ack_i && rnd(2) == 1);
        if (!rtrn_active && allow_ret && issued_tids.size() > 0 && rnd(3) == 0) begin
            idx                 = rnd(issued_tids.size());   // Out of order returns
            l15_rtrn_threadid_i = issued_tids[idx];
            issued_tids.delete(idx);
            case (rnd(4))
                0:       l15_rtrn_type_i = ERR_RET;
                1:       l15_rtrn_type_i = ST_ACK;
                default: l15_rtrn_type_i = LOAD_RET;
            endcase
            l15_rtrn_data_i = {$random(seed), $random(seed), $random(seed), $random(seed)};
            rtrn_active     = 1'b1;
        end
        l15_rtrn_val_i = rtrn_active;
        resp_ready_i   = (rnd(4) != 0);
    endtask

    task automatic wait_idle();
        while (pending.size() > 0 || req_active || issued_tids.size() > 0 || rtrn_active)
            run_cycle();
    endtask

    task automatic run_test(input string name, input int kind, input int n);
        int base;
        base = errors + seq_errors;
        for (int i = 0; i < n; i++) begin
            pending.push_back(make_req(kind));
        end
        wait_idle();
        $display("test %-16s %0d requests, %0d errors", name, n, errors + seq_errors - base);
    endtask

    initial begin
        int wait_cycles;
        rst_ni              = 1'b0;
        req_valid_i         = 1'b0;
        req_pid_i           = '0;
        req_id_i            = '0;
        req_cmd_i           = READ;
        req_cacheable_i     = 1'b0;
        req_addr_i          = '0;
        req_size_i          = '0;
        req_wdata_i         = '0;
        req_wbe_i           = '0;
        l15_header_ack_i    = 1'b0;
        l15_ack_i           = 1'b0;
        l15_rtrn_val_i      = 1'b0;
        l15_rtrn_type_i     = LOAD_RET;
        l15_rtrn_threadid_i = '0;
        l15_rtrn_data_i     = '0;
        resp_ready_i        = 1'b0;
        cur_req             = '0;
        req_active          = 1'b0;
        hdr_taken           = 1'b0;
        rtrn_active         = 1'b0;
        allow_ret           = 1'b0;
        repeat (2) @(negedge clk_i);
        rst_ni = 1'b1;

        // Returns withheld until the pool runs dry
        for (int i = 0; i < 6; i++) begin
            pending.push_back(make_req(K_LOAD));
        end
        while (accepted < NUM_TIDS) run_cycle();
        repeat (10) run_cycle();
        if (accepted != NUM_TIDS) begin
            seq_errors++;
            $display("ERROR: %0d requests accepted with no thread id returned", accepted);
        end
        for (int i = 0; i < NUM_TIDS; i++) begin
            if (issued_tids[i] !== tid_t'(i)) begin
                seq_errors++;
                $display("MISMATCH l15_threadid_o: got 0x%0h, expected 0x%0h",
                         issued_tids[i], i);
            end
        end
        allow_ret   = 1'b1;
        wait_cycles = 0;
        while (accepted < 6 && wait_cycles < 200) begin   // Ample for two returns
            run_cycle();
            wait_cycles++;
        end
        if (accepted != 6) begin
            seq_errors++;
            $display("ERROR: acceptance did not resume after responses were consumed");
        end
        wait_idle();
        $display("test %-16s %0d requests, %0d errors", "tid_limit", 6, errors + seq_errors);

        run_test("loads", K_LOAD, 20);
        run_test("cached_stores", K_CST, 40);
        run_test("uncached_stores", K_UST, 20);
        run_test("mixed", K_MIX, 60);

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors + seq_errors);
        if (errors + seq_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: run did not finish within %0d ns", WATCHDOG_NS);
        $display("sim failed");
        $finish;
    end

endmodule

/* flist.f */
hdl/mem_req_pkg.sv
hdl/l15_msg_pkg.sv
hdl/store_shaper.sv
hdl/req_decoder.sv
hdl/thread_id_pool.sv
hdl/issue_ctrl.sv
hdl/return_router.sv
hdl/l15_adapter.sv
dv/tb_l15_adapter.sv

/* Makefile */
TOOL   = verilator
FLAGS  = --binary --timing --assert -j 0
TOP    = tb_l15_adapter
FLIST  = flist.f
OBJDIR = obj_dir
BIN    = $(OBJDIR)/V$(TOP)
LOG    = sim.log
SRCS   = $(shell cat $(FLIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi
	@grep -q "sim passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
